//--- vlog.f
design/milPkg.sv
design/milLineArbiter.sv
design/milTransmitter.sv
design/milReceiver.sv
design/milTransceiver.sv
tb/milTransceiver_sva.sv
tb/milTransceiverTb.sv

//--- tb/milTransceiverTb.sv
`default_nettype none

module milTransceiverTb import milPkg::*; ;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int ROWS = 11;
	localparam int CYCLE_LIMIT = 400 * ROWS;
	localparam int KIND_TX = 0;
	localparam int KIND_RX = 1;
	localparam int KIND_RX_PENDING_TX = 2;

	logic clk;
	logic rst;
	logic txReq;
	milWord_t txWord;
	logic txCommand;
	logic txAck;
	logic rxValid;
	milWord_t rxWord;
	logic rxIsCommand;
	logic rxAddressed;
	logic rxError;
	logic milInPos;
	logic milInNeg;
	logic milOutPos;
	logic milOutNeg;
	logic receiverBusy;
	logic transmitterBusy;

	string rowName [ROWS];
	int rowKind [ROWS];
	logic rowCommand [ROWS];
	milWord_t rowWord [ROWS];
	logic rowBadParity [ROWS];
	logic expIsCommand [ROWS];
	logic expAddressed [ROWS];
	logic expError [ROWS];

	milWord_t rxWordQ [$];
	logic rxCmdQ [$];
	logic rxAddrQ [$];
	logic rxErrQ [$];
	int cycleCount;
	logic [31:0] lfsrState;

	milTransceiver DUT (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) failRun("Timeout: the tests did not finish in time.");
	end

	// captures every receive push.
	always @(negedge clk) begin
		if (rxValid) begin
			rxWordQ.push_back(rxWord);
			rxCmdQ.push_back(rxIsCommand);
			rxAddrQ.push_back(rxAddressed);
			rxErrQ.push_back(rxError);
		end
	end

	task automatic failRun(input string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input milWord_t expected, input milWord_t actual);
		if (expected !== actual)
			failRun($sformatf("Error %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (expected !== actual)
			failRun($sformatf("Error %s expected %b actual %b", name, expected, actual));
	endtask

	function automatic logic stepLfsr();
		logic out;
		out = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (out) lfsrState = lfsrState ^ 32'hA300_0000;
		return out;
	endfunction

	function automatic milWord_t randomWord();
		milWord_t w;
		for (int i = 0; i < 16; i++) w.data[i] = stepLfsr();
		return w;
	endfunction

	function automatic milWord_t makeCommand(input logic [4:0] addr, input logic [4:0] sub);
		milWord_t w;
		w.command.rtAddress = addr;
		w.command.transmit = 1'b1;
		w.command.subAddress = sub;
		w.command.wordCount = 5'd2;
		return w;
	endfunction

	task automatic addRow(input int r, input string name, input int kind, input logic isCmd,
			input milWord_t word, input logic badParity, input logic eCmd, input logic eAddr,
			input logic eErr);
		rowName[r] = name;
		rowKind[r] = kind;
		rowCommand[r] = isCmd;
		rowWord[r] = word;
		rowBadParity[r] = badParity;
		expIsCommand[r] = eCmd;
		expAddressed[r] = eAddr;
		expError[r] = eErr;
	endtask

	task automatic buildTable();
		addRow(0, "txCommand", KIND_TX, 1, makeCommand(5'd5, 5'd3), 0, 0, 0, 0);
		addRow(1, "txData", KIND_TX, 0, 16'hA5C3, 0, 0, 0, 0);
		// follows a transmit, so it lands in the turnaround.
		addRow(2, "rxTurnaround", KIND_RX, 0, randomWord(), 0, 0, 0, 0);
		addRow(3, "rxDataRandom1", KIND_RX, 0, randomWord(), 0, 0, 0, 0);
		addRow(4, "rxDataRandom2", KIND_RX, 0, randomWord(), 0, 0, 0, 0);
		addRow(5, "rxCmdOwn", KIND_RX, 1, makeCommand(5'd5, 5'd1), 0, 1, 1, 0);
		addRow(6, "rxCmdBroadcast", KIND_RX, 1, makeCommand(5'd31, 5'd7), 0, 1, 1, 0);
		addRow(7, "rxCmdOther", KIND_RX, 1, makeCommand(5'd9, 5'd4), 0, 1, 0, 0);
		addRow(8, "rxBadParity", KIND_RX, 0, randomWord(), 1, 0, 0, 1);
		addRow(9, "rxPendingTx", KIND_RX_PENDING_TX, 1, makeCommand(5'd5, 5'd2), 0, 1, 1, 0);
		addRow(10, "txAfterPending", KIND_TX, 0, randomWord(), 0, 0, 0, 0);
	endtask

	task automatic checkResetState();
		@(negedge clk);
		checkFlag("reset txAck", 1'b0, txAck);
		checkFlag("reset rxValid", 1'b0, rxValid);
		checkFlag("reset milOutPos", 1'b0, milOutPos);
		checkFlag("reset milOutNeg", 1'b0, milOutNeg);
		checkFlag("reset receiverBusy", 1'b0, receiverBusy);
		checkFlag("reset transmitterBusy", 1'b0, transmitterBusy);
	endtask

	// line model: encodes one frame onto milIn.
	task automatic sendFrame(input string name, input logic isCmd, input milWord_t word,
			input logic badParity);
		logic [39:0] halves;
		logic parity;
		halves[39:34] = isCmd ? 6'b111000 : 6'b000111;
		for (int i = 0; i < 16; i++) begin
			halves[33 - 2*i] = word.data[15 - i];
			halves[32 - 2*i] = !word.data[15 - i];
		end
		parity = !(^word.data) ^ badParity; // odd count of ones.
		halves[1] = parity;
		halves[0] = !parity;
		for (int k = 39; k >= 0; k--) begin
			@(posedge clk);
			milInPos <= halves[k];
			milInNeg <= !halves[k];
			if (k == 20) begin // mid frame.
				@(negedge clk);
				checkFlag({name, " receiverBusy"}, 1'b1, receiverBusy);
			end
			repeat (HALF_BIT_CYCLES - 1) @(posedge clk);
		end
		@(posedge clk);
		milInPos <= 1'b0;
		milInNeg <= 1'b0;
	endtask

	task automatic checkReceive(input int r);
		while (rxWordQ.size() == 0) @(negedge clk);
		repeat (HALF_BIT_CYCLES) @(negedge clk);
		checkFlag({rowName[r], " single rxValid"}, 1'b1, rxWordQ.size() == 1);
		checkWord({rowName[r], " rxWord"}, rowWord[r], rxWordQ.pop_front());
		checkFlag({rowName[r], " rxIsCommand"}, expIsCommand[r], rxCmdQ.pop_front());
		checkFlag({rowName[r], " rxAddressed"}, expAddressed[r], rxAddrQ.pop_front());
		checkFlag({rowName[r], " rxError"}, expError[r], rxErrQ.pop_front());
		checkFlag({rowName[r], " receiverBusy idle"}, 1'b0, receiverBusy);
	endtask

	task automatic requestTransmit(input int r);
		@(posedge clk);
		txReq <= 1'b1;
		txWord <= rowWord[r];
		txCommand <= rowCommand[r];
	endtask

	// decodes milOut at mid half-bit, then runs the handshake.
	task automatic finishTransmit(input int r);
		logic [39:0] halves;
		milWord_t got;
		while (!(milOutPos || milOutNeg)) @(negedge clk);
		for (int k = 39; k >= 0; k--) begin
			repeat (k == 39 ? 1 : HALF_BIT_CYCLES) @(negedge clk);
			if (milOutPos == milOutNeg) failRun("Transmitted frame has an invalid line symbol.");
			if (k == 39) checkFlag({rowName[r], " transmitterBusy"}, 1'b1, transmitterBusy);
			halves[k] = milOutPos;
		end
		checkFlag({rowName[r], " command sync"}, rowCommand[r], halves[39:34] == 6'b111000);
		checkFlag({rowName[r], " data sync"}, !rowCommand[r], halves[39:34] == 6'b000111);
		for (int i = 0; i < 17; i++) begin
			checkFlag({rowName[r], " Manchester pair"}, 1'b1, halves[33-2*i] != halves[32-2*i]);
		end
		for (int i = 0; i < 16; i++) got.data[15 - i] = halves[33 - 2*i];
		checkWord({rowName[r], " txFrame"}, rowWord[r], got);
		checkFlag({rowName[r], " odd parity"}, 1'b1, ^{got.data, halves[1]});
		repeat (HALF_BIT_CYCLES - 1) @(negedge clk);
		checkFlag({rowName[r], " txAck rise"}, 1'b1, txAck);
		checkFlag({rowName[r], " line idle"}, 1'b0, milOutPos || milOutNeg);
		@(posedge clk);
		txReq <= 1'b0;
		repeat (2) @(negedge clk);
		checkFlag({rowName[r], " txAck fall"}, 1'b0, txAck);
		checkFlag({rowName[r], " transmitterBusy idle"}, 1'b0, transmitterBusy);
	endtask

	initial begin
		rst = 1'b1;
		txReq = 1'b0;
		txWord = '0;
		txCommand = 1'b0;
		milInPos = 1'b0;
		milInNeg = 1'b0;
		cycleCount = 0;
		lfsrState = 32'd74068;
		buildTable();
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		repeat (2) @(posedge clk);
		checkResetState();
		for (int r = 0; r < ROWS; r++) begin
			if (rowKind[r] == KIND_TX) begin
				requestTransmit(r);
				finishTransmit(r);
			end else if (rowKind[r] == KIND_RX) begin
				sendFrame(rowName[r], rowCommand[r], rowWord[r], rowBadParity[r]);
				checkReceive(r);
			end else begin
				fork
					sendFrame(rowName[r], rowCommand[r], rowWord[r], rowBadParity[r]);
					begin
						repeat (2 * HALF_BIT_CYCLES) @(posedge clk);
						requestTransmit(r);
						while (rxWordQ.size() == 0) begin
							@(negedge clk);
							checkFlag({rowName[r], " milOut idle"}, 1'b0, milOutPos || milOutNeg);
						end
					end
				join
				// the frame starts two cycles after rxValid.
				fork
					checkReceive(r);
					finishTransmit(r);
				join
			end
			repeat (2) @(posedge clk);
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/milTransceiver_sva.sv
`default_nettype none

module milTransceiverSva import milPkg::*; (
	input logic clk,
	input logic rst,
	input logic txReq,
	input logic txAck,
	input logic rxValid,
	input logic milOutPos,
	input logic milOutNeg,
	input logic transmitterBusy
);
	timeunit 1ns;
	timeprecision 1ps;

	lineNotBothHigh: assert property (@(posedge clk) disable iff (rst)
		!(milOutPos && milOutNeg))
		else $error("milOutPos and milOutNeg high together");

	// four-phase return, ack drops only after req.
	ackFallsAfterReq: assert property (@(posedge clk) disable iff (rst)
		$fell(txAck) |-> !$past(txReq))
		else $error("txAck fell while txReq was still high");

	rxValidOneCycle: assert property (@(posedge clk) disable iff (rst)
		rxValid |=> !rxValid)
		else $error("rxValid held longer than one cycle");

	idleWhenNotBusy: assert property (@(posedge clk) disable iff (rst)
		!transmitterBusy |-> (!milOutPos && !milOutNeg))
		else $error("line driven while transmitter not busy");

endmodule

bind milTransceiver milTransceiverSva sva (
	.clk(clk),
	.rst(rst),
	.txReq(txReq),
	.txAck(txAck),
	.rxValid(rxValid),
	.milOutPos(milOutPos),
	.milOutNeg(milOutNeg),
	.transmitterBusy(transmitterBusy)
);

`default_nettype wire

//--- design/milTransceiver.sv
`default_nettype none

module milTransceiver import milPkg::*; (
	input logic clk,
	input logic rst,
	input logic txReq,
	input milWord_t txWord,
	input logic txCommand,
	output logic txAck,
	output logic rxValid,
	output milWord_t rxWord,
	output logic rxIsCommand,
	output logic rxAddressed,
	output logic rxError,
	input logic milInPos,
	input logic milInNeg,
	output logic milOutPos,
	output logic milOutNeg,
	output logic receiverBusy,
	output logic transmitterBusy
);

	logic lineReq;
	logic txGrant;
	logic rxGrant;

	milLineArbiter arbiter (
		.clk(clk),
		.rst(rst),
		.lineReq(lineReq),
		.rxBusy(receiverBusy),
		.txGrant(txGrant),
		.rxGrant(rxGrant)
	);

	milTransmitter transmitter (
		.clk(clk),
		.rst(rst),
		.txReq(txReq),
		.txWord(txWord),
		.txCommand(txCommand),
		.txGrant(txGrant),
		.txAck(txAck),
		.lineReq(lineReq),
		.busy(transmitterBusy),
		.milOutPos(milOutPos),
		.milOutNeg(milOutNeg)
	);

	milReceiver receiver (
		.clk(clk),
		.rst(rst),
		.rxGrant(rxGrant),
		.milInPos(milInPos),
		.milInNeg(milInNeg),
		.busy(receiverBusy),
		.rxValid(rxValid),
		.rxWord(rxWord),
		.rxIsCommand(rxIsCommand),
		.rxAddressed(rxAddressed),
		.rxError(rxError)
	);

endmodule

`default_nettype wire

//--- design/milReceiver.sv
`default_nettype none

module milReceiver import milPkg::*; (
	input logic clk,
	input logic rst,
	input logic rxGrant,
	input logic milInPos,
	input logic milInNeg,
	output logic busy,
	output logic rxValid,
	output milWord_t rxWord,
	output logic rxIsCommand,
	output logic rxAddressed,
	output logic rxError
);

	logic linePos;
	logic lineNeg;
	logic prevPos;
	logic prevNeg;
	logic lineEdge;
	logic startFrame;
	logic sampleNow;
	logic finish;
	logic badSymbol;
	logic [HALF_TIMER_WIDTH-1:0] timer;
	logic [HALF_COUNT_WIDTH-1:0] count;
	logic [WORD_HALF_BITS-1:0] symbols;

	logic [SYNC_HALF_BITS-1:0] syncBits;
	logic [WORD_BITS:0] pairBits; // data bits then parity.
	logic pairError;
	logic commandSync;
	logic dataSync;
	logic addressMatch;
	logic frameError;
	milWord_t decodedWord;

	assign lineEdge = {linePos, lineNeg} != {prevPos, prevNeg};
	assign startFrame = rxGrant && !busy && (linePos || lineNeg) && !(prevPos || prevNeg);
	assign sampleNow = busy && !finish && (timer == HALF_BIT_CYCLES / 2);

	always_ff @(posedge clk) begin
		if (rst) begin
			linePos <= 1'b0;
			lineNeg <= 1'b0;
			prevPos <= 1'b0;
			prevNeg <= 1'b0;
		end else begin
			linePos <= milInPos;
			lineNeg <= milInNeg;
			prevPos <= linePos;
			prevNeg <= lineNeg;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			finish <= 1'b0;
			rxValid <= 1'b0;
			badSymbol <= 1'b0;
			timer <= '0;
			count <= '0;
		end else begin
			rxValid <= 1'b0;
			if (startFrame) begin // first half-bit, cycle 0.
				busy <= 1'b1;
				badSymbol <= 1'b0;
				timer <= HALF_TIMER_WIDTH'(1);
				count <= '0;
			end else if (busy) begin
				if (lineEdge) begin
					timer <= HALF_TIMER_WIDTH'(1); // realign on transitions.
				end else if (timer == HALF_BIT_CYCLES - 1) begin
					timer <= '0;
				end else begin
					timer <= timer + 1'b1;
				end
				if (sampleNow) begin
					badSymbol <= badSymbol || (linePos == lineNeg);
					if (count == WORD_HALF_BITS - 1) begin
						finish <= 1'b1;
					end else begin
						count <= count + 1'b1;
					end
				end
				if (finish) begin
					finish <= 1'b0;
					busy <= 1'b0;
					rxValid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sampleNow) begin
			symbols <= {symbols[WORD_HALF_BITS-2:0], linePos};
		end
		if (finish) begin
			rxWord <= decodedWord;
			rxIsCommand <= commandSync;
			rxAddressed <= commandSync && addressMatch;
			rxError <= frameError;
		end
	end

	always_comb begin
		syncBits = symbols[WORD_HALF_BITS-1 -: SYNC_HALF_BITS];
		pairError = 1'b0;
		pairBits = '0;
		for (int i = 0; i <= WORD_BITS; i++) begin
			pairBits[WORD_BITS-i] = symbols[WORD_HALF_BITS - SYNC_HALF_BITS - 1 - 2*i];
			pairError = pairError || (symbols[WORD_HALF_BITS - SYNC_HALF_BITS - 1 - 2*i] ==
				symbols[WORD_HALF_BITS - SYNC_HALF_BITS - 2 - 2*i]);
		end
		decodedWord.data = pairBits[WORD_BITS:1];
		commandSync = (syncBits == CMD_SYNC);
		dataSync = (syncBits == DATA_SYNC);
		addressMatch = (decodedWord.command.rtAddress == RT_ADDRESS) ||
			(decodedWord.command.rtAddress == BROADCAST_ADDRESS);
		frameError = badSymbol || pairError || !(commandSync || dataSync) || !(^pairBits);
	end

endmodule

`default_nettype wire

//--- design/milTransmitter.sv
`default_nettype none

module milTransmitter import milPkg::*; (
	input logic clk,
	input logic rst,
	input logic txReq,
	input milWord_t txWord,
	input logic txCommand,
	input logic txGrant,
	output logic txAck,
	output logic lineReq,
	output logic busy,
	output logic milOutPos,
	output logic milOutNeg
);

	logic [WORD_HALF_BITS-1:0] frame;
	logic [WORD_HALF_BITS-1:0] nextFrame;
	logic [HALF_TIMER_WIDTH-1:0] halfTimer;
	logic [HALF_COUNT_WIDTH-1:0] halfCount;
	logic sending;
	logic newReq;
	logic startSend;
	logic halfTick;
	logic lastHalf;

	assign newReq = txReq && !lineReq && !txAck;
	assign startSend = lineReq && !sending && txGrant;
	assign halfTick = (halfTimer == HALF_BIT_CYCLES - 1);
	assign lastHalf = (halfCount == WORD_HALF_BITS - 1);
	assign busy = lineReq || txAck;

	// sync, Manchester pairs msb first, then odd parity pair.
	always_comb begin
		nextFrame = '0;
		nextFrame[WORD_HALF_BITS-1 -: SYNC_HALF_BITS] = txCommand ? CMD_SYNC : DATA_SYNC;
		for (int i = 0; i < WORD_BITS; i++) begin
			nextFrame[WORD_HALF_BITS - SYNC_HALF_BITS - 1 - 2*i] = txWord.data[WORD_BITS-1-i];
			nextFrame[WORD_HALF_BITS - SYNC_HALF_BITS - 2 - 2*i] = !txWord.data[WORD_BITS-1-i];
		end
		nextFrame[1] = !(^txWord.data);
		nextFrame[0] = ^txWord.data;
	end

	always_ff @(posedge clk) begin
		if (newReq) begin
			frame <= nextFrame;
		end else if (sending && halfTick && !lastHalf) begin
			frame <= frame << 1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			lineReq <= 1'b0;
			sending <= 1'b0;
			txAck <= 1'b0;
			milOutPos <= 1'b0;
			milOutNeg <= 1'b0;
			halfTimer <= '0;
			halfCount <= '0;
		end else if (newReq) begin
			lineReq <= 1'b1;
		end else if (startSend) begin
			sending <= 1'b1;
			halfTimer <= '0;
			halfCount <= '0;
			milOutPos <= frame[WORD_HALF_BITS-1];
			milOutNeg <= !frame[WORD_HALF_BITS-1];
		end else if (sending) begin
			if (halfTick) begin
				halfTimer <= '0;
				if (lastHalf) begin // word has left the line.
					sending <= 1'b0;
					lineReq <= 1'b0;
					txAck <= 1'b1;
					milOutPos <= 1'b0;
					milOutNeg <= 1'b0;
				end else begin
					halfCount <= halfCount + 1'b1;
					milOutPos <= frame[WORD_HALF_BITS-2];
					milOutNeg <= !frame[WORD_HALF_BITS-2];
				end
			end else begin
				halfTimer <= halfTimer + 1'b1;
			end
		end else if (txAck && !txReq) begin
			txAck <= 1'b0; // four-phase return.
		end
	end

endmodule

`default_nettype wire

//--- design/milLineArbiter.sv
`default_nettype none

module milLineArbiter import milPkg::*; (
	input logic clk,
	input logic rst,
	input logic lineReq,
	input logic rxBusy,
	output logic txGrant,
	output logic rxGrant
);

	logic [1:0] state;
	logic [1:0] nextState;
	logic [HALF_TIMER_WIDTH-1:0] halfTimer;
	logic [TURN_COUNT_WIDTH-1:0] turnCount;
	logic halfTick;
	logic turnDone;

	assign halfTick = (halfTimer == HALF_BIT_CYCLES - 1);
	assign turnDone = halfTick && (turnCount == TURNAROUND_HALF_BITS - 1);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ARB_RECEIVE;
			halfTimer <= '0;
			turnCount <= '0;
		end else begin
			state <= nextState;
			if (state == ARB_WAIT) begin // turnaround runs only here.
				halfTimer <= halfTick ? '0 : halfTimer + 1'b1;
				if (halfTick) begin
					turnCount <= turnCount + 1'b1;
				end
			end else begin
				halfTimer <= '0;
				turnCount <= '0;
			end
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			ARB_RECEIVE: begin
				if (lineReq && !rxBusy) nextState = ARB_TRANSMIT;
			end
			ARB_TRANSMIT: begin
				if (!lineReq) nextState = ARB_WAIT;
			end
			ARB_WAIT: begin
				if (turnDone || rxBusy) nextState = ARB_RECEIVE; // traffic wins.
			end
			default: nextState = ARB_RECEIVE;
		endcase
	end

	assign txGrant = (state == ARB_TRANSMIT);
	assign rxGrant = (state != ARB_TRANSMIT);

endmodule

`default_nettype wire

//--- design/milPkg.sv
`default_nettype none

package milPkg;

	localparam int HALF_BIT_CYCLES = 4; // clocks per half-bit.
	localparam int SYNC_HALF_BITS = 6;
	localparam int WORD_HALF_BITS = 40; // sync, 16 data bits, parity.
	localparam int TURNAROUND_HALF_BITS = 8;
	localparam int WORD_BITS = 16;

	localparam int HALF_TIMER_WIDTH = $clog2(HALF_BIT_CYCLES);
	localparam int HALF_COUNT_WIDTH = $clog2(WORD_HALF_BITS);
	localparam int TURN_COUNT_WIDTH = $clog2(TURNAROUND_HALF_BITS);

	// one bit per half-bit, 1 is high and 0 is low.
	localparam logic [SYNC_HALF_BITS-1:0] CMD_SYNC = 6'b111000;
	localparam logic [SYNC_HALF_BITS-1:0] DATA_SYNC = 6'b000111;

	localparam logic [4:0] RT_ADDRESS = 5'd5;
	localparam logic [4:0] BROADCAST_ADDRESS = 5'd31; // all terminals.

	// line ownership states.
	localparam logic [1:0] ARB_RECEIVE = 2'd0;
	localparam logic [1:0] ARB_TRANSMIT = 2'd1;
	localparam logic [1:0] ARB_WAIT = 2'd2;

	typedef struct packed {
		logic [4:0] rtAddress;
		logic transmit;
		logic [4:0] subAddress;
		logic [4:0] wordCount; // or mode code.
	} milCommand_t;

	typedef union packed {
		milCommand_t command;
		logic [WORD_BITS-1:0] data;
	} milWord_t;

endpackage

`default_nettype wire
